// File: logic/mem_tile_pkg.sv
/*
 * Geometry of the memory tile: wide line, SRAM banks and macro rows.
 * Address fields are derived here so that every block slices the
 * byte address the same way.
 */

package mem_tile_pkg;

  //////////////////////////////////////////////////////////////////////
  // Line and bank geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned LineWidth       = 256;
  localparam int unsigned SramDataWidth   = 64;
  localparam int unsigned SramNumWords    = 64;
  localparam int unsigned NumBanksPerWord = LineWidth / SramDataWidth;
  localparam int unsigned NumBankRows     = 2;

  // Address fields, low to high
  localparam int unsigned SramByteOffsetWidth = $clog2(SramDataWidth / 8);
  localparam int unsigned SramBankSelWidth    = $clog2(NumBanksPerWord);
  localparam int unsigned SramAddrWidth       = $clog2(SramNumWords);
  localparam int unsigned SramMacroSelWidth   = $clog2(NumBankRows);

  localparam int unsigned SramAddrWidthOffset = SramByteOffsetWidth + SramBankSelWidth;
  localparam int unsigned SramMacroSelOffset  = SramAddrWidthOffset + SramAddrWidth;

  // Byte address covering every row of the tile
  localparam int unsigned AddrWidth = SramMacroSelOffset + SramMacroSelWidth;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [LineWidth-1:0]         line_t;
  typedef logic [LineWidth/8-1:0]       line_be_t;
  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [SramDataWidth-1:0]     sram_data_t;
  typedef logic [SramDataWidth/8-1:0]   sram_be_t;
  typedef logic [SramAddrWidth-1:0]     sram_addr_t;
  typedef logic [SramMacroSelWidth-1:0] macro_sel_t;

endpackage

// File: logic/amo_pkg.sv
/*
 * Atomic memory operations resolved in front of the SRAM banks.
 * The operand is one 32-bit lane of the wide line.
 */

package amo_pkg;

  typedef enum logic [2:0] {
    AMO_NONE = 3'd0,
    AMO_SWAP = 3'd1,
    AMO_ADD  = 3'd2,
    AMO_AND  = 3'd3,
    AMO_OR   = 3'd4
  } amo_op_e;

  localparam int unsigned AmoWordWidth = 32;

  typedef logic [AmoWordWidth-1:0] amo_word_t;

  // Lane of the line that an atomic works on
  localparam int unsigned AmoLanesPerLine  = 8;
  localparam int unsigned AmoLaneSelOffset = $clog2(AmoWordWidth / 8);
  localparam int unsigned AmoLaneSelWidth  = $clog2(AmoLanesPerLine);

endpackage

// File: logic/mem_port_if.sv
/*
 * One wide memory access from the atomic resolver to the bank array.
 * The memory side is always ready; rdata is valid one cycle after a read.
 */

`timescale 1ns/10ps

interface mem_port_if;
  import mem_tile_pkg::*;

  logic     req;
  logic     we;
  addr_t    addr;
  line_t    wdata;
  line_be_t be;
  line_t    rdata;

  modport issuer (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rdata
  );

  modport memory (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

// File: logic/sram_macro.sv
/*
 * Behavioral single-port SRAM with byte enables.
 * Stands in for a vendor macro; read data is registered, one cycle latency.
 */

`timescale 1ns/10ps

module sram_macro #(
  parameter int unsigned NumWords = mem_tile_pkg::SramNumWords
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  mem_tile_pkg::sram_addr_t addr_i,
  input  mem_tile_pkg::sram_data_t wdata_i,
  input  mem_tile_pkg::sram_be_t   be_i,
  output mem_tile_pkg::sram_data_t rdata_o
);
  import mem_tile_pkg::*;

  sram_data_t mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes change
        for (int b = 0; b < $bits(sram_be_t); b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: logic/sram_bank_array.sv
/*
 * Wide line storage built from narrow SRAM macros.
 * Each line is striped across the banks, the row comes from the high
 * address bits; the read row is registered to steer the returned data.
 */

`timescale 1ns/10ps

module sram_bank_array (
  input logic      clk_i,
  input logic      rst_i,
  mem_port_if.memory mem
);
  import mem_tile_pkg::*;

  sram_addr_t sram_addr;
  macro_sel_t macro_sel;
  macro_sel_t macro_sel_q;

  sram_data_t [NumBankRows-1:0][NumBanksPerWord-1:0] sram_rdata_split;

  //////////////////////////////////////////////////////////////////////
  // Address slicing
  //////////////////////////////////////////////////////////////////////

  assign sram_addr = mem.addr[SramAddrWidthOffset +: SramAddrWidth];
  assign macro_sel = mem.addr[SramMacroSelOffset +: SramMacroSelWidth];

  // Row of the last read, valid when its data leaves the macros
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      macro_sel_q <= '0;
    end else if (mem.req && !mem.we) begin
      macro_sel_q <= macro_sel;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Banks and macro rows
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumBanksPerWord; i++) begin : gen_sram_banks
    sram_data_t bank_wdata;
    sram_be_t   bank_be;

    assign bank_wdata = mem.wdata[i*SramDataWidth +: SramDataWidth];
    assign bank_be    = mem.be[i*$bits(sram_be_t) +: $bits(sram_be_t)];

    assign mem.rdata[i*SramDataWidth +: SramDataWidth] = sram_rdata_split[macro_sel_q][i];

    for (genvar j = 0; j < NumBankRows; j++) begin : gen_sram_macros
      // Only the addressed row sees the strobe
      sram_macro #(
        .NumWords(SramNumWords)
      ) i_macro (
        .clk_i,
        .req_i  (mem.req && (macro_sel == macro_sel_t'(j))),
        .we_i   (mem.we),
        .addr_i (sram_addr),
        .wdata_i(bank_wdata),
        .be_i   (bank_be),
        .rdata_o(sram_rdata_split[j][i])
      );
    end
  end

endmodule

// File: logic/amo_resolver.sv
/*
 * Resolves atomics in front of the SRAM banks.
 * Plain accesses pass straight through; an atomic reads the line, returns
 * it next cycle and writes the modified 32-bit lane back in that cycle.
 */

`timescale 1ns/10ps

module amo_resolver (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  mem_tile_pkg::addr_t    addr_i,
  input  mem_tile_pkg::line_t    wdata_i,
  input  mem_tile_pkg::line_be_t be_i,
  input  amo_pkg::amo_op_e       atop_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output mem_tile_pkg::line_t    rdata_o,
  mem_port_if.issuer             mem
);
  import mem_tile_pkg::*;
  import amo_pkg::*;

  logic accept;
  logic is_amo;
  logic rvalid_q;
  logic amo_pending_q;

  logic [AmoLaneSelWidth-1:0] req_lane;
  logic [AmoLaneSelWidth-1:0] wb_lane;

  // Pending atomic, captured on acceptance
  amo_op_e   amo_op_q;
  addr_t     amo_addr_q;
  amo_word_t amo_operand_q;

  amo_word_t old_word;
  amo_word_t new_word;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Banks are busy with the write-back right after an atomic
  assign gnt_o    = !amo_pending_q;
  assign accept   = req_i && gnt_o;
  assign is_amo   = (atop_i != AMO_NONE);
  assign rvalid_o = rvalid_q;
  assign rdata_o  = mem.rdata;

  assign req_lane = addr_i[AmoLaneSelOffset +: AmoLaneSelWidth];
  assign wb_lane  = amo_addr_q[AmoLaneSelOffset +: AmoLaneSelWidth];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q      <= 1'b0;
      amo_pending_q <= 1'b0;
    end else begin
      rvalid_q      <= accept;
      amo_pending_q <= accept && is_amo;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_amo) begin
      amo_op_q      <= atop_i;
      amo_addr_q    <= addr_i;
      amo_operand_q <= wdata_i[req_lane*AmoWordWidth +: AmoWordWidth];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Atomic operation
  //////////////////////////////////////////////////////////////////////

  assign old_word = mem.rdata[wb_lane*AmoWordWidth +: AmoWordWidth];

  always_comb begin
    case (amo_op_q)
      AMO_SWAP: new_word = amo_operand_q;
      AMO_ADD:  new_word = old_word + amo_operand_q;
      AMO_AND:  new_word = old_word & amo_operand_q;
      AMO_OR:   new_word = old_word | amo_operand_q;
      default:  new_word = old_word;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Memory port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (amo_pending_q) begin
      // Write back the lane, other bytes stay masked
      mem.req   = 1'b1;
      mem.we    = 1'b1;
      mem.addr  = amo_addr_q;
      mem.wdata = {AmoLanesPerLine{new_word}};
      mem.be    = '0;
      mem.be[wb_lane*(AmoWordWidth/8) +: (AmoWordWidth/8)] = '1;
    end else begin
      // An atomic starts as a plain read of its line
      mem.req   = req_i;
      mem.we    = we_i && !is_amo;
      mem.addr  = addr_i;
      mem.wdata = wdata_i;
      mem.be    = be_i;
    end
  end

endmodule

// File: logic/mem_tile.sv
/*
 * Memory tile top level with an OBI-style request port.
 * Atomics are resolved ahead of the wide SRAM bank array.
 */

`timescale 1ns/10ps

module mem_tile (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  mem_tile_pkg::addr_t    addr_i,
  input  mem_tile_pkg::line_t    wdata_i,
  input  mem_tile_pkg::line_be_t be_i,
  input  amo_pkg::amo_op_e       atop_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output mem_tile_pkg::line_t    rdata_o
);

  mem_port_if mem_port ();

  amo_resolver i_amo_resolver (
    .clk_i,
    .rst_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .atop_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .mem     (mem_port.issuer)
  );

  sram_bank_array i_sram_bank_array (
    .clk_i,
    .rst_i,
    .mem   (mem_port.memory)
  );

endmodule

// File: verification/mem_tile_tb.sv
/*
 * Self-checking testbench for the memory tile.
 * Runs directed and LFSR-driven requests, predicts every returned line
 * with a reference model and compares it, and the grant, each cycle.
 */

`timescale 1ns/10ps

module mem_tile_tb;
  import mem_tile_pkg::*;
  import amo_pkg::*;

  localparam int ClkPeriod     = 10;
  localparam int NumFillLines  = 20;
  localparam int NumPartial    = 8;
  localparam int NumAmo        = 8;
  localparam int NumRandom     = 200;
  localparam int NumRequests   = 2*NumFillLines + 2*NumPartial + 2*NumAmo + NumRandom;
  localparam int TimeoutCycles = NumRequests * 3 + 100;

  typedef logic [AddrWidth-SramAddrWidthOffset-1:0] line_idx_t;

  typedef struct packed {
    line_t       line;
    logic        check;
    logic        amo;
    int unsigned cycle;
  } expect_t;

  logic     clk_i;
  logic     rst_i;
  logic     req_i;
  logic     we_i;
  addr_t    addr_i;
  line_t    wdata_i;
  line_be_t be_i;
  amo_op_e  atop_i;
  logic     gnt_o;
  logic     rvalid_o;
  line_t    rdata_o;

  logic [15:0] lfsr_state = 16'd86;
  int unsigned cycle_count = 0;
  line_t       ref_mem [line_idx_t];
  expect_t     expect_q [$];

  mem_tile dut0 (
    .clk_i,
    .rst_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .atop_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o
  );

  always #(ClkPeriod/2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_line(input line_t got, input line_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // One LFSR step per bit taken, each new bit shifted in at the low end
  function automatic line_t take_bits(input int n);
    line_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[LineWidth-2:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // Words 0..7, 37 and 63 of each row
  function automatic addr_t fill_addr(input int k);
    sram_addr_t word;
    int         slot;
    slot = k % 10;
    if (slot < 8) begin
      word = sram_addr_t'(slot);
    end else if (slot == 8) begin
      word = sram_addr_t'(37);
    end else begin
      word = sram_addr_t'(63);
    end
    return {macro_sel_t'(k / 10), word, {SramAddrWidthOffset{1'b0}}};
  endfunction

  // Lines 0..7 of a random row at a random byte offset
  function automatic addr_t rand_addr();
    addr_t row;
    addr_t low;
    row = addr_t'(take_bits(SramMacroSelWidth)) << SramMacroSelOffset;
    low = addr_t'(take_bits(SramAddrWidthOffset + 3));
    return row | low;
  endfunction

  // Reference model that returns the line as it was before the access
  function automatic line_t apply_reference(input logic we, input addr_t addr,
                                            input line_t wdata, input line_be_t be,
                                            input amo_op_e op);
    line_idx_t                  idx;
    logic [AmoLaneSelWidth-1:0] lane;
    line_t                      old_line;
    line_t                      new_line;
    amo_word_t                  operand;
    amo_word_t                  old_word;
    amo_word_t                  new_word;
    idx  = addr[AddrWidth-1:SramAddrWidthOffset];
    lane = addr[AmoLaneSelOffset +: AmoLaneSelWidth];
    old_line = ref_mem.exists(idx) ? ref_mem[idx] : '0;
    new_line = old_line;
    if (op != AMO_NONE) begin
      operand  = wdata[lane*AmoWordWidth +: AmoWordWidth];
      old_word = old_line[lane*AmoWordWidth +: AmoWordWidth];
      case (op)
        AMO_SWAP: new_word = operand;
        AMO_ADD:  new_word = old_word + operand;
        AMO_AND:  new_word = old_word & operand;
        AMO_OR:   new_word = old_word | operand;
        default:  new_word = old_word;
      endcase
      new_line[lane*AmoWordWidth +: AmoWordWidth] = new_word;
    end else if (we) begin
      for (int b = 0; b < LineWidth/8; b++) begin
        if (be[b]) begin
          new_line[b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    ref_mem[idx] = new_line;
    return old_line;
  endfunction

  // Called at posedge + 1 and returns at posedge + 1 after acceptance
  task automatic send_request(input logic we, input addr_t addr, input line_t wdata,
                              input line_be_t be, input amo_op_e op);
    expect_t exp;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    atop_i  = op;
    // Request stays up while the banks are busy
    while (gnt_o !== 1'b1) begin
      next_cycle();
    end
    exp.line  = apply_reference(we, addr, wdata, be, op);
    exp.check = (op != AMO_NONE) || !we;
    exp.amo   = (op != AMO_NONE);
    exp.cycle = cycle_count + 1;
    expect_q.push_back(exp);
    next_cycle();
    req_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (expect_q.size() != 0 && expect_q[0].cycle == cycle_count) begin
        check_flag(rvalid_o, 1'b1, "rvalid_o one cycle after acceptance");
        check_flag(gnt_o, !expect_q[0].amo, "gnt_o in the cycle after acceptance");
        if (expect_q[0].check) begin
          check_line(rdata_o, expect_q[0].line, "rdata_o");
        end
        void'(expect_q.pop_front());
      end else begin
        check_flag(rvalid_o, 1'b0, "rvalid_o without accepted request");
        check_flag(gnt_o, 1'b1, "gnt_o with no atomic write-back");
      end
    end
  end

  initial begin : watchdog
    #(TimeoutCycles * ClkPeriod);
    abort_run("Timeout: the tests did not finish in the expected number of cycles");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    addr_t      req_addr;
    line_t      req_data;
    line_be_t   req_be;
    amo_op_e    req_op;
    logic [1:0] kind;
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    atop_i  = AMO_NONE;
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    check_flag(gnt_o, 1'b1, "gnt_o after reset");
    check_flag(rvalid_o, 1'b0, "rvalid_o after reset");

    // Full lines in both rows and their read-back
    for (int k = 0; k < NumFillLines; k++) begin
      send_request(1'b1, fill_addr(k), take_bits(LineWidth), '1, AMO_NONE);
    end
    for (int k = 0; k < NumFillLines; k++) begin
      send_request(1'b0, fill_addr(k), '0, '0, AMO_NONE);
    end

    for (int k = 0; k < NumPartial; k++) begin
      req_be = line_be_t'(take_bits(LineWidth/8));
      send_request(1'b1, fill_addr(2*k + 1), take_bits(LineWidth), req_be, AMO_NONE);
      send_request(1'b0, fill_addr(2*k + 1), '0, '0, AMO_NONE);
    end

    // Each opcode twice and each followed by a read of its line
    for (int k = 0; k < NumAmo; k++) begin
      req_addr = fill_addr(2*k + 2) | addr_t'(take_bits(SramAddrWidthOffset));
      req_op   = amo_op_e'(3'(k % 4 + 1));
      send_request(1'b0, req_addr, take_bits(LineWidth), '0, req_op);
      send_request(1'b0, req_addr, '0, '0, AMO_NONE);
    end

    for (int k = 0; k < NumRandom; k++) begin
      kind     = 2'(take_bits(2));
      req_addr = rand_addr();
      req_data = take_bits(LineWidth);
      req_be   = line_be_t'(take_bits(LineWidth/8));
      req_op   = amo_op_e'(3'(take_bits(2)) + 3'd1);
      case (kind)
        2'd0:    send_request(1'b0, req_addr, '0, '0, AMO_NONE);
        2'd1:    send_request(1'b1, req_addr, req_data, '1, AMO_NONE);
        2'd2:    send_request(1'b1, req_addr, req_data, req_be, AMO_NONE);
        default: send_request(1'b0, req_addr, req_data, '0, req_op);
      endcase
    end

    repeat (3) next_cycle();
    if (expect_q.size() != 0) begin
      abort_run($sformatf("%0d accepted requests never returned rvalid_o",
                          expect_q.size()));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// File: mem_tile.f
logic/mem_tile_pkg.sv
logic/amo_pkg.sv
logic/mem_port_if.sv
logic/sram_macro.sv
logic/sram_bank_array.sv
logic/amo_resolver.sv
logic/mem_tile.sv
verification/mem_tile_tb.sv

// File: Makefile
# Verilator simulation of the memory tile

TOP = mem_tile_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -j 0 --top-module $(TOP) -f mem_tile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
